// File: hw/cache_pkg.sv
package cache_pkg;

  // address split into tag, index, word offset and byte offset
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int BYTE_OFF_W = 2;
  localparam int WORD_IDX_W = 4;
  localparam int INDEX_W    = 5;
  localparam int TAG_W      = ADDR_W - INDEX_W - WORD_IDX_W - BYTE_OFF_W;
  localparam int OPAQUE_W   = 8;
  localparam int MSG_TYPE_W = 3;

  localparam int DEF_NUM_LINES      = 32;
  localparam int DEF_WORDS_PER_LINE = 16;
  localparam int LINE_W             = WORD_W * DEF_WORDS_PER_LINE;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [OPAQUE_W-1:0]   opaque_t;
  typedef logic [MSG_TYPE_W-1:0] msg_type_t;

  localparam msg_type_t MSG_READ  = 3'd0;
  localparam msg_type_t MSG_WRITE = 3'd1;

  typedef struct packed {
    msg_type_t type_;
    opaque_t   opaque;
    addr_t     addr;
    word_t     data;
  } mem_req_t;

  typedef struct packed {
    msg_type_t type_;
    opaque_t   opaque;
    word_t     data;
  } mem_resp_t;

endpackage

// File: hw/cache_dpath.sv
`timescale 1ns/1ps

module cache_dpath #(
  parameter int NUM_LINES      = cache_pkg::DEF_NUM_LINES,
  parameter int WORDS_PER_LINE = cache_pkg::DEF_WORDS_PER_LINE
) (
  input  logic                 clk,
  input  logic                 reset,

  input  cache_pkg::mem_req_t  proc_req_msg,
  input  cache_pkg::mem_resp_t mem_resp_msg,
  output cache_pkg::mem_resp_t proc_resp_msg,
  output cache_pkg::mem_req_t  mem_req_msg,

  // from the controller
  input  logic                 latch_req,
  input  logic                 array_sel_flush,
  input  cache_pkg::index_t    flush_index,
  input  cache_pkg::word_idx_t word_cnt,
  input  logic                 fill_word_en,
  input  logic                 cpu_write_en,
  input  logic                 tag_write_en,
  input  logic                 set_dirty,
  input  logic                 clear_dirty,
  input  logic                 wb_phase,
  input  logic                 mem_write,

  // to the controller
  output logic                 hit,
  output logic                 line_dirty,
  output logic                 req_is_write
);
  import cache_pkg::*;

  mem_req_t  req_reg;
  tag_t      req_tag;
  index_t    req_index;
  word_idx_t req_word;
  index_t    idx;

  tag_t      tag_array  [NUM_LINES];
  line_t     data_array [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;

  line_t     cur_line;
  word_t     resp_word;
  word_t     xfer_word;
  tag_t      addr_tag;

  word_idx_t wr_word;
  word_t     wr_data;
  logic [WORDS_PER_LINE-1:0] word_en;

  // request register held for the whole access
  always_ff @(posedge clk) begin
    if (latch_req) begin
      req_reg <= proc_req_msg;
    end
  end

  assign req_tag   = req_reg.addr[ADDR_W-1 -: TAG_W];
  assign req_index = req_reg.addr[BYTE_OFF_W+WORD_IDX_W +: INDEX_W];
  assign req_word  = req_reg.addr[BYTE_OFF_W +: WORD_IDX_W];

  assign idx = array_sel_flush ? flush_index : req_index; // flush walks its own counter

  assign req_is_write = (req_reg.type_ == MSG_WRITE);

  // valid and dirty bits per line
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (tag_write_en) begin
        valid[idx] <= 1'b1;
      end
      if (set_dirty) begin
        dirty[idx] <= 1'b1;
      end else if (clear_dirty) begin
        dirty[idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write_en) begin
      tag_array[idx] <= req_tag; // refill always installs the request tag
    end
  end

  // write source is the refill word from memory or the store data
  assign wr_word = fill_word_en ? word_cnt : req_word;
  assign wr_data = fill_word_en ? mem_resp_msg.data : req_reg.data;
  assign word_en = (fill_word_en || cpu_write_en) ?
                   ({{(WORDS_PER_LINE-1){1'b0}}, 1'b1} << wr_word) : '0;

  always_ff @(posedge clk) begin
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      if (word_en[w]) begin
        data_array[idx][w*WORD_W +: WORD_W] <= wr_data;
      end
    end
  end

  // lookup
  assign cur_line   = data_array[idx];
  assign hit        = valid[idx] && (tag_array[idx] == req_tag);
  assign line_dirty = valid[idx] && dirty[idx];

  assign resp_word = cur_line[req_word*WORD_W +: WORD_W];
  assign xfer_word = cur_line[word_cnt*WORD_W +: WORD_W]; // write-back data

  // processor response with the opaque echoed
  always_comb begin
    proc_resp_msg.type_  = req_reg.type_;
    proc_resp_msg.opaque = req_reg.opaque;
    proc_resp_msg.data   = resp_word;
  end

  // victim line address on write-back and request line on refill
  assign addr_tag = wb_phase ? tag_array[idx] : req_tag;

  always_comb begin
    mem_req_msg.type_  = mem_write ? MSG_WRITE : MSG_READ;
    mem_req_msg.opaque = '0;
    mem_req_msg.addr   = {addr_tag, idx, word_cnt, {BYTE_OFF_W{1'b0}}};
    mem_req_msg.data   = xfer_word;
  end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int WORDS_PER_LINE = cache_pkg::DEF_WORDS_PER_LINE,
  parameter int NUM_LINES      = cache_pkg::DEF_NUM_LINES
) (
  input  logic                 clk,
  input  logic                 reset,

  // handshakes
  input  logic                 proc_req,
  output logic                 proc_ack,
  input  logic                 flush_req,
  output logic                 flush_ack,
  output logic                 mem_req,
  input  logic                 mem_ack,

  // status from the datapath
  input  logic                 hit,
  input  logic                 line_dirty,
  input  logic                 req_is_write,

  // datapath control
  output logic                 latch_req,
  output logic                 array_sel_flush,
  output cache_pkg::index_t    flush_index,
  output cache_pkg::word_idx_t word_cnt,
  output logic                 fill_word_en,
  output logic                 cpu_write_en,
  output logic                 tag_write_en,
  output logic                 set_dirty,
  output logic                 clear_dirty,
  output logic                 wb_phase,
  output logic                 mem_write
);
  import cache_pkg::*;

  localparam word_idx_t LAST_WORD = word_idx_t'(WORDS_PER_LINE - 1);
  localparam index_t    LAST_LINE = index_t'(NUM_LINES - 1);

  typedef enum logic [3:0] {
    IDLE,
    COMPARE,
    WB_REQ,
    WB_WAIT,
    FILL_REQ,
    FILL_WAIT,
    RESPOND,
    FLUSH_CHECK,
    FLUSH_REQ,
    FLUSH_WAIT,
    FLUSH_DONE
  } state_t;

  state_t state;
  state_t state_next;

  logic word_done;   // memory ack has fallen so one word is finished
  logic word_last;
  logic line_last;
  logic line_advance;

  assign word_done = ((state == WB_WAIT) || (state == FILL_WAIT) ||
                      (state == FLUSH_WAIT)) && !mem_ack;
  assign word_last = (word_cnt == LAST_WORD);
  assign line_last = (flush_index == LAST_LINE);

  // flush moves on after a clean line or after the last write-back word
  assign line_advance = ((state == FLUSH_CHECK) && !line_dirty) ||
                        ((state == FLUSH_WAIT) && word_done && word_last);

  always_comb begin
    state_next      = state;
    latch_req       = 1'b0;
    array_sel_flush = 1'b0;
    mem_req         = 1'b0;
    fill_word_en    = 1'b0;
    cpu_write_en    = 1'b0;
    tag_write_en    = 1'b0;
    set_dirty       = 1'b0;
    clear_dirty     = 1'b0;
    wb_phase        = 1'b0;
    mem_write       = 1'b0;

    case (state)
      IDLE: begin
        if (proc_req) begin
          latch_req  = 1'b1;
          state_next = COMPARE;
        end else if (flush_req) begin
          state_next = FLUSH_CHECK;
        end
      end

      COMPARE: begin
        if (hit) begin
          cpu_write_en = req_is_write;
          set_dirty    = req_is_write;
          state_next   = RESPOND;
        end else if (line_dirty) begin
          state_next = WB_REQ; // evict the victim first
        end else begin
          state_next = FILL_REQ;
        end
      end

      WB_REQ: begin
        mem_req   = 1'b1;
        mem_write = 1'b1;
        wb_phase  = 1'b1;
        if (mem_ack) begin
          state_next = WB_WAIT;
        end
      end

      WB_WAIT: begin
        mem_write = 1'b1;
        wb_phase  = 1'b1;
        if (word_done) begin
          if (word_last) begin
            clear_dirty = 1'b1;
            state_next  = FILL_REQ;
          end else begin
            state_next = WB_REQ;
          end
        end
      end

      FILL_REQ: begin
        mem_req = 1'b1;
        if (mem_ack) begin
          fill_word_en = 1'b1; // data valid on the first ack cycle
          state_next   = FILL_WAIT;
        end
      end

      FILL_WAIT: begin
        if (word_done) begin
          if (word_last) begin
            tag_write_en = 1'b1;
            state_next   = COMPARE; // access now completes as a hit
          end else begin
            state_next = FILL_REQ;
          end
        end
      end

      RESPOND: begin
        if (proc_ack && !proc_req) begin
          state_next = IDLE;
        end
      end

      FLUSH_CHECK: begin
        array_sel_flush = 1'b1;
        if (line_dirty) begin
          state_next = FLUSH_REQ;
        end else if (line_last) begin
          state_next = FLUSH_DONE;
        end
      end

      FLUSH_REQ: begin
        array_sel_flush = 1'b1;
        mem_req         = 1'b1;
        mem_write       = 1'b1;
        wb_phase        = 1'b1;
        if (mem_ack) begin
          state_next = FLUSH_WAIT;
        end
      end

      FLUSH_WAIT: begin
        array_sel_flush = 1'b1;
        mem_write       = 1'b1;
        wb_phase        = 1'b1;
        if (word_done) begin
          if (word_last) begin
            clear_dirty = 1'b1; // valid stays set
            state_next  = line_last ? FLUSH_DONE : FLUSH_CHECK;
          end else begin
            state_next = FLUSH_REQ;
          end
        end
      end

      FLUSH_DONE: begin
        if (flush_ack && !flush_req) begin
          state_next = IDLE;
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      word_cnt    <= '0;
      flush_index <= '0;
      proc_ack    <= 1'b0;
      flush_ack   <= 1'b0;
    end else begin
      state <= state_next;

      if (word_done) begin
        word_cnt <= word_last ? '0 : word_cnt + 1'b1;
      end

      if (line_advance) begin
        flush_index <= line_last ? '0 : flush_index + 1'b1;
      end

      // ack one cycle into RESPOND and dropped after proc_req falls
      if (state == RESPOND) begin
        if (!proc_ack) begin
          proc_ack <= 1'b1;
        end else if (!proc_req) begin
          proc_ack <= 1'b0;
        end
      end

      if (state == FLUSH_DONE) begin
        if (!flush_ack) begin
          flush_ack <= 1'b1;
        end else if (!flush_req) begin
          flush_ack <= 1'b0;
        end
      end
    end
  end

endmodule

// File: hw/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
  parameter int NUM_LINES      = cache_pkg::DEF_NUM_LINES,
  parameter int WORDS_PER_LINE = cache_pkg::DEF_WORDS_PER_LINE
) (
  input  logic                 clk,
  input  logic                 reset,

  // processor side
  input  logic                 proc_req,
  input  cache_pkg::mem_req_t  proc_req_msg,
  output logic                 proc_ack,
  output cache_pkg::mem_resp_t proc_resp_msg,

  // flush
  input  logic                 flush_req,
  output logic                 flush_ack,

  // memory side with the cache as master
  output logic                 mem_req,
  output cache_pkg::mem_req_t  mem_req_msg,
  input  logic                 mem_ack,
  input  cache_pkg::mem_resp_t mem_resp_msg
);
  import cache_pkg::*;

  logic      latch_req;
  logic      array_sel_flush;
  index_t    flush_index;
  word_idx_t word_cnt;
  logic      fill_word_en;
  logic      cpu_write_en;
  logic      tag_write_en;
  logic      set_dirty;
  logic      clear_dirty;
  logic      wb_phase;
  logic      mem_write;
  logic      hit;
  logic      line_dirty;
  logic      req_is_write;

  cache_ctrl #(
    .WORDS_PER_LINE (WORDS_PER_LINE),
    .NUM_LINES      (NUM_LINES)
  ) u_ctrl (
    .clk             (clk),
    .reset           (reset),
    .proc_req        (proc_req),
    .proc_ack        (proc_ack),
    .flush_req       (flush_req),
    .flush_ack       (flush_ack),
    .mem_req         (mem_req),
    .mem_ack         (mem_ack),
    .hit             (hit),
    .line_dirty      (line_dirty),
    .req_is_write    (req_is_write),
    .latch_req       (latch_req),
    .array_sel_flush (array_sel_flush),
    .flush_index     (flush_index),
    .word_cnt        (word_cnt),
    .fill_word_en    (fill_word_en),
    .cpu_write_en    (cpu_write_en),
    .tag_write_en    (tag_write_en),
    .set_dirty       (set_dirty),
    .clear_dirty     (clear_dirty),
    .wb_phase        (wb_phase),
    .mem_write       (mem_write)
  );

  cache_dpath #(
    .NUM_LINES      (NUM_LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_dpath (
    .clk             (clk),
    .reset           (reset),
    .proc_req_msg    (proc_req_msg),
    .mem_resp_msg    (mem_resp_msg),
    .proc_resp_msg   (proc_resp_msg),
    .mem_req_msg     (mem_req_msg),
    .latch_req       (latch_req),
    .array_sel_flush (array_sel_flush),
    .flush_index     (flush_index),
    .word_cnt        (word_cnt),
    .fill_word_en    (fill_word_en),
    .cpu_write_en    (cpu_write_en),
    .tag_write_en    (tag_write_en),
    .set_dirty       (set_dirty),
    .clear_dirty     (clear_dirty),
    .wb_phase        (wb_phase),
    .mem_write       (mem_write),
    .hit             (hit),
    .line_dirty      (line_dirty),
    .req_is_write    (req_is_write)
  );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
  parameter int MEM_WORDS = 4096
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_req,
  input  cache_pkg::mem_req_t  mem_req_msg,
  output logic                 mem_ack,
  output cache_pkg::mem_resp_t mem_resp_msg
);
  import cache_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  word_t         mem [MEM_WORDS];
  logic          busy;   // request seen and waiting out the delay
  int            delay;
  logic [AW-1:0] waddr;

  // every word starts as its byte address xor a fixed pattern
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= addr_t'(i << 2) ^ 32'h5A5A_0000;
    end
  end

  assign waddr = mem_req_msg.addr[AW+1:2];

  always @(posedge clk) begin
    if (reset) begin
      mem_ack      <= 1'b0;
      mem_resp_msg <= '0;
      busy         <= 1'b0;
      delay        <= 0;
    end else if (mem_ack) begin
      if (!mem_req) begin
        mem_ack <= 1'b0; // return to zero
      end
    end else if (mem_req) begin
      if (!busy) begin
        busy  <= 1'b1;
        delay <= $urandom_range(3, 0); // ack 1 to 4 cycles later
      end else if (delay > 0) begin
        delay <= delay - 1;
      end else begin
        busy                <= 1'b0;
        mem_ack             <= 1'b1;
        mem_resp_msg.type_  <= mem_req_msg.type_;
        mem_resp_msg.opaque <= mem_req_msg.opaque;
        if (mem_req_msg.type_ == MSG_WRITE) begin
          mem[waddr]        <= mem_req_msg.data;
          mem_resp_msg.data <= '0;
        end else begin
          mem_resp_msg.data <= mem[waddr];
        end
      end
    end
  end

endmodule

// File: tb/cache_properties.sv
`timescale 1ns/1ps

module cache_properties (
  input logic                clk,
  input logic                reset,
  input logic                proc_req,
  input logic                proc_ack,
  input logic                flush_req,
  input logic                flush_ack,
  input logic                mem_req,
  input logic                mem_ack,
  input cache_pkg::mem_req_t mem_req_msg
);

  a_proc_ack_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(proc_ack) |-> proc_req)
    else $error("proc_ack rose while proc_req was low");

  // request and message held until the memory answers
  a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
    (mem_req && !mem_ack) |=> (mem_req && $stable(mem_req_msg)))
    else $error("mem_req or mem_req_msg changed before mem_ack");

  a_flush_ack_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(flush_ack) |-> flush_req)
    else $error("flush_ack rose while flush_req was low");

endmodule

bind cache_top cache_properties u_props (
  .clk         (clk),
  .reset       (reset),
  .proc_req    (proc_req),
  .proc_ack    (proc_ack),
  .flush_req   (flush_req),
  .flush_ack   (flush_ack),
  .mem_req     (mem_req),
  .mem_ack     (mem_ack),
  .mem_req_msg (mem_req_msg)
);

// File: tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int MEM_WORDS     = 4096;
  localparam int REQ_TIMEOUT   = 2000;
  localparam int FLUSH_TIMEOUT = 20000;
  localparam int RANDOM_OPS    = 48;

  logic      clk;
  logic      reset;
  logic      proc_req;
  mem_req_t  proc_req_msg;
  logic      proc_ack;
  mem_resp_t proc_resp_msg;
  logic      flush_req;
  logic      flush_ack;
  logic      mem_req;
  mem_req_t  mem_req_msg;
  logic      mem_ack;
  mem_resp_t mem_resp_msg;

  word_t ref_mem [MEM_WORDS];
  int    rd_count  = 0;
  int    wr_count  = 0;
  logic  mem_req_q = 1'b0;
  int    errors    = 0;
  int    errors_at_start;
  int    tests_run    = 0;
  int    tests_failed = 0;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  cache_top #(
    .NUM_LINES      (DEF_NUM_LINES),
    .WORDS_PER_LINE (DEF_WORDS_PER_LINE)
  ) u_dut (
    .clk           (clk),
    .reset         (reset),
    .proc_req      (proc_req),
    .proc_req_msg  (proc_req_msg),
    .proc_ack      (proc_ack),
    .proc_resp_msg (proc_resp_msg),
    .flush_req     (flush_req),
    .flush_ack     (flush_ack),
    .mem_req       (mem_req),
    .mem_req_msg   (mem_req_msg),
    .mem_ack       (mem_ack),
    .mem_resp_msg  (mem_resp_msg)
  );

  mem_model #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk          (clk),
    .reset        (reset),
    .mem_req      (mem_req),
    .mem_req_msg  (mem_req_msg),
    .mem_ack      (mem_ack),
    .mem_resp_msg (mem_resp_msg)
  );

  // memory transactions counted on each rising edge of mem_req
  always @(posedge clk) begin
    mem_req_q <= mem_req;
    if (mem_req && !mem_req_q) begin
      if (mem_req_msg.type_ == MSG_WRITE) begin
        wr_count <= wr_count + 1;
      end else begin
        rd_count <= rd_count + 1;
      end
    end
  end

  function automatic word_t pattern_word(input addr_t addr);
    return addr ^ 32'h5A5A_0000;
  endfunction

  function automatic int word_index(input addr_t addr);
    return int'(addr[13:2]);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_proc_ack(input logic level, output int cycles);
    cycles = 0;
    @(posedge clk);
    cycles = 1;
    while (proc_ack !== level && cycles < REQ_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (proc_ack === level) else begin
      $display("Timeout at %0t ns: proc_ack never went to %0b", $time, level);
      errors++;
    end
  endtask

  task automatic wait_flush_ack(input logic level);
    int cycles;
    cycles = 0;
    while (flush_ack !== level && cycles < FLUSH_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    assert (flush_ack === level) else begin
      $display("Timeout at %0t ns: flush_ack never went to %0b", $time, level);
      errors++;
    end
  endtask

  // one four-phase processor transaction with latency counted from the edge
  // where proc_req is first sampled to the edge where proc_ack rose
  task automatic cpu_access(input msg_type_t kind, input addr_t addr, input word_t data,
                            input opaque_t id, output mem_resp_t resp, output int latency);
    mem_req_t msg;
    int       cycles;
    msg.type_  = kind;
    msg.opaque = id;
    msg.addr   = addr;
    msg.data   = data;
    @(posedge clk);
    proc_req     <= 1'b1;
    proc_req_msg <= msg;
    wait_proc_ack(1'b1, cycles);
    resp    = proc_resp_msg;
    latency = cycles - 2;
    proc_req <= 1'b0;
    wait_proc_ack(1'b0, cycles);
  endtask

  task automatic read_and_check(input addr_t addr, input opaque_t id,
                                output word_t data, output int latency);
    mem_resp_t resp;
    cpu_access(MSG_READ, addr, '0, id, resp, latency);
    data = resp.data;
    check_value("proc_resp_msg.data", resp.data, ref_mem[word_index(addr)]);
    check_value("proc_resp_msg.opaque", resp.opaque, id);
    check_value("proc_resp_msg.type_", resp.type_, MSG_READ);
  endtask

  task automatic write_word(input addr_t addr, input word_t data, input opaque_t id,
                            output int latency);
    mem_resp_t resp;
    cpu_access(MSG_WRITE, addr, data, id, resp, latency);
    ref_mem[word_index(addr)] = data;
    check_value("proc_resp_msg.opaque", resp.opaque, id);
    check_value("proc_resp_msg.type_", resp.type_, MSG_WRITE);
  endtask

  task automatic run_flush();
    @(posedge clk);
    flush_req <= 1'b1;
    wait_flush_ack(1'b1);
    flush_req <= 1'b0;
    wait_flush_ack(1'b0);
  endtask

  task automatic compare_memory();
    int bad;
    bad = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (u_mem.mem[i] !== ref_mem[i]) begin
        bad++;
        if (bad <= 4) begin
          check_value($sformatf("u_mem.mem[%0d]", i), u_mem.mem[i], ref_mem[i]);
        end
      end
    end
    check_value("memory mismatch count", bad, 0);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  task automatic test_read_miss();
    int    rd0;
    int    wr0;
    int    lat;
    word_t data;
    errors_at_start = errors;
    rd0 = rd_count;
    wr0 = wr_count;
    read_and_check(32'h0000_0104, 8'h11, data, lat);
    check_value("read data vs pattern", data, pattern_word(32'h0000_0104));
    check_value("memory read count", rd_count - rd0, 16);
    check_value("memory write count", wr_count - wr0, 0);
    report_test("read miss after reset");
  endtask

  task automatic test_read_hit();
    int    rd0;
    int    wr0;
    int    lat;
    word_t data;
    errors_at_start = errors;
    rd0 = rd_count;
    wr0 = wr_count;
    read_and_check(32'h0000_0108, 8'h12, data, lat);
    check_value("proc_ack latency", lat, 2);
    read_and_check(32'h0000_013C, 8'h13, data, lat); // last word of the line
    check_value("proc_ack latency", lat, 2);
    check_value("memory read count", rd_count - rd0, 0);
    check_value("memory write count", wr_count - wr0, 0);
    report_test("read hit");
  endtask

  task automatic test_write_hit();
    int    rd0;
    int    wr0;
    int    lat;
    word_t data;
    errors_at_start = errors;
    rd0 = rd_count;
    wr0 = wr_count;
    write_word(32'h0000_0110, 32'hDEAD_BEEF, 8'h20, lat);
    check_value("proc_ack latency", lat, 2);
    read_and_check(32'h0000_0110, 8'h21, data, lat);
    check_value("memory read count", rd_count - rd0, 0);
    check_value("memory write count", wr_count - wr0, 0);
    report_test("write hit then read");
  endtask

  task automatic test_dirty_evict();
    int    rd0;
    int    wr0;
    int    lat;
    word_t data;
    errors_at_start = errors;
    rd0 = rd_count;
    wr0 = wr_count;
    read_and_check(32'h0000_0910, 8'h30, data, lat); // same index as 0x110 with tag 1
    check_value("memory write count", wr_count - wr0, 16);
    check_value("memory read count", rd_count - rd0, 16);
    check_value("u_mem.mem[0x110]", u_mem.mem[word_index(32'h0000_0110)], 32'hDEAD_BEEF);
    rd0 = rd_count;
    wr0 = wr_count;
    read_and_check(32'h0000_0110, 8'h31, data, lat);
    check_value("memory read count", rd_count - rd0, 16);
    check_value("memory write count", wr_count - wr0, 0);
    report_test("dirty eviction");
  endtask

  task automatic test_flush();
    int rd0;
    int wr0;
    int lat;
    errors_at_start = errors;
    write_word(32'h0000_0044, 32'h1111_0001, 8'h40, lat);
    write_word(32'h0000_0088, 32'h2222_0002, 8'h41, lat);
    write_word(32'h0000_00CC, 32'h3333_0003, 8'h42, lat);
    rd0 = rd_count;
    wr0 = wr_count;
    run_flush();
    check_value("memory write count", wr_count - wr0, 48); // three dirty lines
    check_value("memory read count", rd_count - rd0, 0);
    compare_memory();
    rd0 = rd_count;
    wr0 = wr_count;
    run_flush();
    check_value("memory write count", wr_count - wr0, 0);
    check_value("memory read count", rd_count - rd0, 0);
    report_test("flush");
  endtask

  task automatic test_random_mix();
    addr_t addr;
    word_t data;
    int    lat;
    errors_at_start = errors;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      addr = addr_t'($urandom_range(MEM_WORDS - 1, 0)) << 2;
      if ($urandom_range(1, 0) == 1) begin
        write_word(addr, $urandom, opaque_t'(n), lat);
      end else begin
        read_and_check(addr, opaque_t'(n), data, lat);
      end
    end
    run_flush();
    compare_memory();
    report_test("random mix");
  endtask

  initial begin
    int cycles;
    void'($urandom(13));
    proc_req     <= 1'b0;
    proc_req_msg <= '0;
    flush_req    <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = pattern_word(addr_t'(i << 2));
    end

    cycles = 0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    assert (reset === 1'b0) else begin
      $display("Timeout at %0t ns: reset was never released", $time);
      errors++;
    end

    test_read_miss();
    test_read_hit();
    test_write_hit();
    test_dirty_evict();
    test_flush();
    test_random_mix();

    $display("summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/cache_pkg.sv
hw/cache_dpath.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tb/tb_clock.sv
tb/mem_model.sv
tb/cache_properties.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb \
  --Mdir obj_dir -o cache_sim \
  -f vlog.f

./obj_dir/cache_sim | tee sim.log

# the log decides, not the exit code of the simulator
if grep -q 'All tests passed!' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
